/* design/lane_rotator_settings.svh */
// Lane rotator geometry: lane count, lane width and rotate select width
`ifndef LANE_ROTATOR_SETTINGS_SVH
`define LANE_ROTATOR_SETTINGS_SVH

// Byte lanes across the load data path
`define LR_LANES 16

// Bits carried by one lane
`define LR_LANE_WIDTH 8

// Rotate and algebraic select width
// Upper two bits pick a four-lane group step, lower two a single-lane step
`define LR_ROT_BITS 4

`endif

/* design/lane_rotator_pkg.sv */
// Lane rotator types: access size encoding and data, mask and select words
`default_nettype none

`include "lane_rotator_settings.svh"

package lane_rotator_pkg;

   // One-hot access size, leftmost bit is the full 16 byte access
   typedef enum logic [0:4] {
      size_16 = 5'b10000,
      size_8  = 5'b01000,
      size_4  = 5'b00100,
      size_2  = 5'b00010,
      size_1  = 5'b00001
   } opsize_e;

   // Lane 0 sits in the most significant bits of the word
   typedef logic [0:`LR_LANES-1][`LR_LANE_WIDTH-1:0] lane_data_t;

   typedef logic [0:`LR_LANES-1] lane_mask_t;

   typedef logic [0:`LR_ROT_BITS-1] rot_sel_t;

endpackage

`default_nettype wire

/* design/rot_ctl_stage.sv */
// Rotator control stage: resolves endian selects and registers them with the lane mask
`timescale 1ns/1ns
`default_nettype none

`include "lane_rotator_settings.svh"

module rot_ctl_stage (
   input  logic                        nclk,
   input  logic                        reset,
   input  logic                        le,
   input  logic                        algebraic,
   input  lane_rotator_pkg::opsize_e   opsize,
   input  lane_rotator_pkg::rot_sel_t  be_rotate_sel,
   input  lane_rotator_pkg::rot_sel_t  le_rotate_sel,
   input  lane_rotator_pkg::rot_sel_t  be_algebraic_sel,
   input  lane_rotator_pkg::rot_sel_t  le_algebraic_sel,
   output logic                        le_q,
   output logic                        algebraic_q,
   output lane_rotator_pkg::rot_sel_t  rot_sel,
   output lane_rotator_pkg::rot_sel_t  alg_sel,
   output lane_rotator_pkg::lane_mask_t lane_mask
);

   localparam int LANES     = `LR_LANES;
   localparam int SIZE_BITS = $bits(lane_rotator_pkg::opsize_e);

   lane_rotator_pkg::rot_sel_t   rot_sel_d;
   lane_rotator_pkg::rot_sel_t   alg_sel_d;
   lane_rotator_pkg::lane_mask_t lane_mask_d;

   // Only one select of each kind travels on to the data stage
   assign rot_sel_d = le ? le_rotate_sel : be_rotate_sel;
   assign alg_sel_d = le ? le_algebraic_sel : be_algebraic_sel;

   // A lane survives when the access reaches from it to the last lane
   always_comb begin
      lane_mask_d = '0;
      for (int i = 0; i < LANES; i++) begin
         for (int k = 0; k < SIZE_BITS; k++) begin
            if ((LANES >> k) >= (LANES - i)) begin
               lane_mask_d[i] = lane_mask_d[i] | opsize[k];
            end
         end
      end
   end

   always_ff @(posedge nclk) begin
      if (reset) begin
         le_q        <= 1'b0;
         algebraic_q <= 1'b0;
         rot_sel     <= '0;
         alg_sel     <= '0;
         // Decoded size_16, every lane enabled
         lane_mask   <= '1;
      end else begin
         le_q        <= le;
         algebraic_q <= algebraic;
         rot_sel     <= rot_sel_d;
         alg_sel     <= alg_sel_d;
         lane_mask   <= lane_mask_d;
      end
   end

endmodule

`default_nettype wire

/* design/rot_lane_rotate.sv */
// Rotator data path: bypass source select, endian reversal and two-step lane rotation
`timescale 1ns/1ns
`default_nettype none

`include "lane_rotator_settings.svh"

module rot_lane_rotate (
   input  logic                        le_q,
   input  lane_rotator_pkg::rot_sel_t  rot_sel,
   input  lane_rotator_pkg::lane_data_t arr_data,
   input  lane_rotator_pkg::lane_data_t stq7_rmw_data,
   input  lane_rotator_pkg::lane_data_t stq8_rmw_data,
   input  logic                        stq_byp_val,
   input  logic                        stq7_byp_val,
   output lane_rotator_pkg::lane_data_t rot_data,
   output lane_rotator_pkg::lane_data_t src_data
);

   localparam int LANES = `LR_LANES;
   // Lane distance of one group step
   localparam int GRP   = LANES / 4;

   lane_rotator_pkg::lane_data_t byp_data;
   lane_rotator_pkg::lane_data_t bele_data;
   lane_rotator_pkg::lane_data_t grp_data;

   // Store queue stage 7 wins over stage 8, and either wins over the array
   assign byp_data = stq7_byp_val ? stq7_rmw_data : stq8_rmw_data;
   assign src_data = stq_byp_val ? byp_data : arr_data;

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         bele_data[i] = le_q ? src_data[LANES-1-i] : src_data[i];
      end
   end

   // First level moves whole groups of four lanes to the right
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         case (rot_sel[0:1])
            2'd0:    grp_data[i] = bele_data[i];
            2'd1:    grp_data[i] = bele_data[(i + LANES - GRP) % LANES];
            2'd2:    grp_data[i] = bele_data[(i + LANES - 2 * GRP) % LANES];
            default: grp_data[i] = bele_data[(i + LANES - 3 * GRP) % LANES];
         endcase
      end
   end

   // Second level finishes with a shift of zero to three lanes
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         case (rot_sel[2:3])
            2'd0:    rot_data[i] = grp_data[i];
            2'd1:    rot_data[i] = grp_data[(i + LANES - 1) % LANES];
            2'd2:    rot_data[i] = grp_data[(i + LANES - 2) % LANES];
            default: rot_data[i] = grp_data[(i + LANES - 3) % LANES];
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/rot_mask_stage.sv */
// Rotator output stage: lane masking, algebraic sign pick and output register
`timescale 1ns/1ns
`default_nettype none

`include "lane_rotator_settings.svh"

module rot_mask_stage (
   input  logic                         nclk,
   input  logic                         reset,
   input  lane_rotator_pkg::lane_data_t rot_data,
   input  lane_rotator_pkg::lane_data_t src_data,
   input  lane_rotator_pkg::lane_mask_t lane_mask,
   input  lane_rotator_pkg::rot_sel_t   alg_sel,
   input  logic                         algebraic_q,
   output lane_rotator_pkg::lane_data_t data_rot,
   output logic                         sign_bit
);

   localparam int LANES = `LR_LANES;
   localparam int MSB   = `LR_LANE_WIDTH - 1;
   localparam int GRP   = LANES / 4;

   lane_rotator_pkg::lane_data_t masked_data;
   logic [0:GRP-1]               grp_top;
   logic                         sign_d;

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         masked_data[i] = lane_mask[i] ? rot_data[i] : '0;
      end
   end

   // Sign comes from the source before rotation, first the four-lane group
   always_comb begin
      for (int j = 0; j < GRP; j++) begin
         case (alg_sel[0:1])
            2'd0:    grp_top[j] = src_data[j][MSB];
            2'd1:    grp_top[j] = src_data[GRP + j][MSB];
            2'd2:    grp_top[j] = src_data[2 * GRP + j][MSB];
            default: grp_top[j] = src_data[3 * GRP + j][MSB];
         endcase
      end
   end

   // then the lane within that group
   assign sign_d = algebraic_q & grp_top[alg_sel[2:3]];

   always_ff @(posedge nclk) begin
      if (reset) begin
         data_rot <= '0;
         sign_bit <= 1'b0;
      end else begin
         data_rot <= masked_data;
         sign_bit <= sign_d;
      end
   end

endmodule

`default_nettype wire

/* design/lane_rotator.sv */
// Load data lane rotator: control stage feeding the rotate and mask data stage
`timescale 1ns/1ns
`default_nettype none

module lane_rotator (
   input  logic                         nclk,
   input  logic                         reset,
   input  logic                         le,
   input  logic                         algebraic,
   input  lane_rotator_pkg::opsize_e    opsize,
   input  lane_rotator_pkg::rot_sel_t   be_rotate_sel,
   input  lane_rotator_pkg::rot_sel_t   le_rotate_sel,
   input  lane_rotator_pkg::rot_sel_t   be_algebraic_sel,
   input  lane_rotator_pkg::rot_sel_t   le_algebraic_sel,
   input  lane_rotator_pkg::lane_data_t arr_data,
   input  lane_rotator_pkg::lane_data_t stq7_rmw_data,
   input  lane_rotator_pkg::lane_data_t stq8_rmw_data,
   input  logic                         stq_byp_val,
   input  logic                         stq7_byp_val,
   output lane_rotator_pkg::lane_data_t data_rot,
   output logic                         sign_bit
);

   logic                         le_q;
   logic                         algebraic_q;
   lane_rotator_pkg::rot_sel_t   rot_sel;
   lane_rotator_pkg::rot_sel_t   alg_sel;
   lane_rotator_pkg::lane_mask_t lane_mask;
   lane_rotator_pkg::lane_data_t rot_data;
   lane_rotator_pkg::lane_data_t src_data;

   // Controls arrive one cycle ahead of the data they steer
   rot_ctl_stage i_ctl (
      .nclk             (nclk),
      .reset            (reset),
      .le               (le),
      .algebraic        (algebraic),
      .opsize           (opsize),
      .be_rotate_sel    (be_rotate_sel),
      .le_rotate_sel    (le_rotate_sel),
      .be_algebraic_sel (be_algebraic_sel),
      .le_algebraic_sel (le_algebraic_sel),
      .le_q             (le_q),
      .algebraic_q      (algebraic_q),
      .rot_sel          (rot_sel),
      .alg_sel          (alg_sel),
      .lane_mask        (lane_mask)
   );

   rot_lane_rotate i_rotate (
      .le_q          (le_q),
      .rot_sel       (rot_sel),
      .arr_data      (arr_data),
      .stq7_rmw_data (stq7_rmw_data),
      .stq8_rmw_data (stq8_rmw_data),
      .stq_byp_val   (stq_byp_val),
      .stq7_byp_val  (stq7_byp_val),
      .rot_data      (rot_data),
      .src_data      (src_data)
   );

   rot_mask_stage i_mask (
      .nclk        (nclk),
      .reset       (reset),
      .rot_data    (rot_data),
      .src_data    (src_data),
      .lane_mask   (lane_mask),
      .alg_sel     (alg_sel),
      .algebraic_q (algebraic_q),
      .data_rot    (data_rot),
      .sign_bit    (sign_bit)
   );

endmodule

`default_nettype wire

/* verif/rot_clock_gen.sv */
// Lane rotator testbench clock: free-running 40 ns clock
`timescale 1ns/1ns
`default_nettype none

module rot_clock_gen #(
   parameter int HALF_PERIOD = 20
) (
   output logic nclk
);

   initial nclk = 1'b0;

   always #(HALF_PERIOD) nclk = ~nclk;

endmodule

`default_nettype wire

/* verif/rot_checker.sv */
// Output stage assertions: lane masking, sign gating and output values after reset
`timescale 1ns/1ns
`default_nettype none

`include "lane_rotator_settings.svh"

module rot_checker (
   input logic                         nclk,
   input logic                         reset,
   input lane_rotator_pkg::lane_data_t data_rot,
   input logic                         sign_bit,
   input lane_rotator_pkg::lane_mask_t lane_mask,
   input logic                         algebraic_q
);

   lane_rotator_pkg::lane_mask_t live_lanes;
   int mask_fails = 0;
   int sign_fails = 0;
   int reset_fails = 0;

   always_comb begin
      for (int i = 0; i < `LR_LANES; i++) begin
         live_lanes[i] = |data_rot[i];
      end
   end

   // The mask seen at one edge governs the word registered at that edge
   a_mask_zero: assert property (@(posedge nclk)
      !reset |=> ((live_lanes & ~$past(lane_mask)) == '0))
      else begin
         $error("data_rot holds a nonzero lane outside the lane mask");
         mask_fails++;
      end

   a_sign_gate: assert property (@(posedge nclk) (!reset && !algebraic_q) |=> !sign_bit)
      else begin
         $error("sign_bit set for a non-algebraic operation");
         sign_fails++;
      end

   a_reset_zero: assert property (@(posedge nclk) reset |=> (data_rot == '0 && !sign_bit))
      else begin
         $error("outputs not cleared by reset");
         reset_fails++;
      end

endmodule

`default_nettype wire

/* verif/rot_monitor.sv */
// Lane rotator scoreboard: reference model of both stages and the output comparator
`timescale 1ns/1ns
`default_nettype none

`include "lane_rotator_settings.svh"

module rot_monitor (
   input  logic                         nclk,
   input  logic                         reset,
   input  logic                         le,
   input  logic                         algebraic,
   input  lane_rotator_pkg::opsize_e    opsize,
   input  lane_rotator_pkg::rot_sel_t   be_rotate_sel,
   input  lane_rotator_pkg::rot_sel_t   le_rotate_sel,
   input  lane_rotator_pkg::rot_sel_t   be_algebraic_sel,
   input  lane_rotator_pkg::rot_sel_t   le_algebraic_sel,
   input  lane_rotator_pkg::lane_data_t arr_data,
   input  lane_rotator_pkg::lane_data_t stq7_rmw_data,
   input  lane_rotator_pkg::lane_data_t stq8_rmw_data,
   input  logic                         stq_byp_val,
   input  logic                         stq7_byp_val,
   input  lane_rotator_pkg::lane_data_t data_rot,
   input  logic                         sign_bit,
   input  int                           op_tag,
   input  int                           test_num,
   output int                           done_tag,
   output int                           checks,
   output int                           errors
);

   localparam int LANES = `LR_LANES;
   localparam int MSB   = `LR_LANE_WIDTH - 1;

   lane_rotator_pkg::lane_data_t src;
   lane_rotator_pkg::lane_data_t rev;
   lane_rotator_pkg::lane_data_t exp_data;
   logic exp_sign;
   logic exp_known;
   int   exp_tag;
   // Model of the control registers, one operation ahead of the data
   logic q_le;
   logic q_alg;
   int   q_size;
   int   q_rsel;
   int   q_asel;
   int   q_tag;
   int   test_checks;
   int   test_errors;
   int   last_test;

   function automatic int size_lanes(input lane_rotator_pkg::opsize_e s);
      case (s)
         lane_rotator_pkg::size_8: return 8;
         lane_rotator_pkg::size_4: return 4;
         lane_rotator_pkg::size_2: return 2;
         lane_rotator_pkg::size_1: return 1;
         default:                  return LANES;
      endcase
   endfunction

   function automatic string test_name(input int t);
      case (t)
         1:       return "reset values";
         2:       return "big-endian rotation";
         3:       return "little-endian reversal";
         4:       return "bypass priority";
         5:       return "size masking";
         default: return "sign bit";
      endcase
   endfunction

   initial begin
      exp_known   = 1'b0;
      done_tag    = 0;
      checks      = 0;
      errors      = 0;
      test_checks = 0;
      test_errors = 0;
      last_test   = 0;
   end

   // Inputs and outputs both settle well before the falling edge
   always @(negedge nclk) begin
      if (test_num != last_test) begin
         if (last_test != 0) begin
            $display("Test %0d %s: %0d checks, %0d errors", last_test,
                     test_name(last_test), test_checks, test_errors);
         end
         last_test   = test_num;
         test_checks = 0;
         test_errors = 0;
      end
      if (exp_known) begin
         checks++;
         test_checks++;
         if (data_rot !== exp_data) begin
            $display("Error at %0t ns: data_rot expected %h, actual %h",
                     $time, exp_data, data_rot);
            errors++;
            test_errors++;
         end
         if (sign_bit !== exp_sign) begin
            $display("Error at %0t ns: sign_bit expected %b, actual %b",
                     $time, exp_sign, sign_bit);
            errors++;
            test_errors++;
         end
         if (exp_tag != 0) begin
            done_tag = exp_tag;
         end
      end
      if (reset) begin
         exp_data = '0;
         exp_sign = 1'b0;
         exp_tag  = 0;
         q_le     = 1'b0;
         q_alg    = 1'b0;
         q_size   = LANES;
         q_rsel   = 0;
         q_asel   = 0;
         q_tag    = 0;
      end else begin
         src = stq_byp_val ? (stq7_byp_val ? stq7_rmw_data : stq8_rmw_data) : arr_data;
         for (int i = 0; i < LANES; i++) begin
            rev[i] = q_le ? src[LANES-1-i] : src[i];
         end
         for (int i = 0; i < LANES; i++) begin
            exp_data[i] = (i >= LANES - q_size) ? rev[(i - q_rsel + LANES) % LANES] : '0;
         end
         exp_sign = q_alg & src[q_asel][MSB];
         exp_tag  = q_tag;
         q_le     = le;
         q_alg    = algebraic;
         q_size   = size_lanes(opsize);
         q_rsel   = int'(le ? le_rotate_sel : be_rotate_sel);
         q_asel   = int'(le ? le_algebraic_sel : be_algebraic_sel);
         q_tag    = op_tag;
      end
      exp_known = 1'b1;
   end

endmodule

`default_nettype wire

/* verif/tb_lane_rotator.sv */
// Lane rotator testbench top: reset, random operation stimulus and closing summary
`timescale 1ns/1ns
`default_nettype none

module tb_lane_rotator;

   localparam int OPS_PER_TEST = 40;
   localparam int DRAIN_LIMIT  = 20;

   logic                         nclk;
   logic                         reset;
   logic                         le;
   logic                         algebraic;
   logic                         stq_byp_val;
   logic                         stq7_byp_val;
   logic                         sign_bit;
   lane_rotator_pkg::opsize_e    opsize;
   lane_rotator_pkg::rot_sel_t   be_rotate_sel;
   lane_rotator_pkg::rot_sel_t   le_rotate_sel;
   lane_rotator_pkg::rot_sel_t   be_algebraic_sel;
   lane_rotator_pkg::rot_sel_t   le_algebraic_sel;
   lane_rotator_pkg::lane_data_t arr_data;
   lane_rotator_pkg::lane_data_t stq7_rmw_data;
   lane_rotator_pkg::lane_data_t stq8_rmw_data;
   lane_rotator_pkg::lane_data_t data_rot;
   int          op_tag;
   int          test_num;
   int          done_tag;
   int          checks;
   int          errors;
   int          assert_fails;
   int          next_tag;
   logic [31:0] rng;
   logic        timed_out;

   rot_clock_gen i_clk (.nclk(nclk));

   lane_rotator i_dut (.*);

   rot_monitor i_mon (.*);

   bind rot_mask_stage rot_checker i_checker (
      .nclk        (nclk),
      .reset       (reset),
      .data_rot    (data_rot),
      .sign_bit    (sign_bit),
      .lane_mask   (lane_mask),
      .algebraic_q (algebraic_q)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Test 1 drives zero data, tests 2 and 3 keep the array source, later tests randomize more
   task automatic drive_cycle(input int mode, input logic with_op);
      logic [31:0] d [13];
      logic [31:0] w;
      for (int k = 0; k < 13; k++) begin
         rng  = lcg_step(rng);
         d[k] = rng;
      end
      w = d[12];
      test_num      <= mode;
      arr_data      <= (mode == 1) ? '0 : {d[0], d[1], d[2], d[3]};
      stq7_rmw_data <= (mode == 1) ? '0 : {d[4], d[5], d[6], d[7]};
      stq8_rmw_data <= (mode == 1) ? '0 : {d[8], d[9], d[10], d[11]};
      stq_byp_val   <= (mode >= 4) ? w[31] : 1'b0;
      stq7_byp_val  <= (mode >= 4) ? w[30] : 1'b0;
      if (with_op) begin
         next_tag++;
         op_tag           <= next_tag;
         le               <= (mode == 3) ? 1'b1 : ((mode == 2) ? 1'b0 : w[29]);
         algebraic        <= (mode >= 4) ? w[28] : 1'b0;
         opsize           <= (mode >= 5) ?
                             lane_rotator_pkg::opsize_e'(5'b10000 >> (w[27:25] % 3'd5)) :
                             lane_rotator_pkg::size_16;
         be_rotate_sel    <= w[24:21];
         le_rotate_sel    <= w[20:17];
         be_algebraic_sel <= w[16:13];
         le_algebraic_sel <= w[12:9];
      end else begin
         op_tag           <= 0;
         le               <= 1'b0;
         algebraic        <= 1'b0;
         opsize           <= lane_rotator_pkg::size_16;
         be_rotate_sel    <= '0;
         le_rotate_sel    <= '0;
         be_algebraic_sel <= '0;
         le_algebraic_sel <= '0;
      end
   endtask

   task automatic run_test(input int mode, input int cycles);
      int waited;
      for (int k = 0; k < cycles; k++) begin
         @(posedge nclk);
         drive_cycle(mode, mode != 1);
      end
      waited = 0;
      while (done_tag != next_tag && waited < DRAIN_LIMIT) begin
         @(posedge nclk);
         drive_cycle(mode, 1'b0);
         waited++;
      end
      if (done_tag != next_tag) begin
         $display("Timeout: operation %0d of test %0d never reached the output", next_tag, mode);
         timed_out = 1'b1;
      end
   endtask

   initial begin
      rng              = 32'h9ef8abc2;
      next_tag         = 0;
      timed_out        = 1'b0;
      reset            = 1'b1;
      le               = 1'b0;
      algebraic        = 1'b0;
      opsize           = lane_rotator_pkg::size_16;
      be_rotate_sel    = '0;
      le_rotate_sel    = '0;
      be_algebraic_sel = '0;
      le_algebraic_sel = '0;
      // Array data is live during reset, so data_rot reads 0 only through its reset
      arr_data         = {4{rng}};
      stq7_rmw_data    = '0;
      stq8_rmw_data    = '0;
      stq_byp_val      = 1'b0;
      stq7_byp_val     = 1'b0;
      op_tag           = 0;
      test_num         = 1;
      repeat (3) @(posedge nclk);
      reset <= 1'b0;
      for (int t = 1; t <= 6; t++) begin
         if (!timed_out) begin
            run_test(t, (t == 1) ? 6 : OPS_PER_TEST);
         end
      end
      @(posedge nclk);
      test_num <= 0;
      // Gives the monitor time to report the last test
      repeat (2) @(posedge nclk);
      assert_fails = i_dut.i_mask.i_checker.mask_fails + i_dut.i_mask.i_checker.sign_fails
                   + i_dut.i_mask.i_checker.reset_fails;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0 && !timed_out) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* lane_rotator.f */
+incdir+design
design/lane_rotator_pkg.sv
design/rot_ctl_stage.sv
design/rot_lane_rotate.sv
design/rot_mask_stage.sv
design/lane_rotator.sv
verif/rot_clock_gen.sv
verif/rot_checker.sv
verif/rot_monitor.sv
verif/tb_lane_rotator.sv

/* run.sh */
#!/bin/sh
# Builds the lane rotator testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ns --top-module tb_lane_rotator \
   -f lane_rotator.f -o sim_lane_rotator || exit 1
out=$(./obj_dir/sim_lane_rotator +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
